//--- Bender.yml
package:
  name: ex_unit

sources:
  - include_dirs:
      - include
    files:
      - verilog/ex_pkg.sv
      - verilog/alu.sv
      - verilog/pc_update.sv
      - verilog/ex_unit.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/ex_unit_tb.sv

//--- files.f
+incdir+include
verilog/ex_pkg.sv
verilog/alu.sv
verilog/pc_update.sv
verilog/ex_unit.sv
test/ex_unit_tb.sv

//--- include/ex_config.svh
// Execute stage width and register number macros
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

//////////////////////////////
// Datapath widths
//////////////////////////////

`define EX_DATA_W      16   // Data, PC and immediate width
`define EX_REG_ADDR_W  4    // Register file address width

//////////////////////////////
// Instruction fields
//////////////////////////////

`define EX_CALL_W      12   // Absolute call target field

// Register that holds the stack pointer
`define EX_SP_REG      15   // Call and ret_future write here

`endif

//--- test/ex_unit_tb.sv
// Execute stage testbench with clock, reset, LFSR stimulus, reference model and output checks
`timescale 1ns/1ps
`default_nettype none

`include "ex_config.svh"

module ex_unit_tb;

    logic clk;
    logic reset;
    logic in_valid;
    logic reg_write, mem_to_reg, reg_to_mem, ret_future;
    logic call, ret, branch, alu_src, load_half, half_spec;
    ex_pkg::alu_op_e      alu_op;
    ex_pkg::branch_cond_e branch_cond;
    ex_pkg::shamt_t       shift;
    ex_pkg::data_t        rd_data_1, rd_data_2, sign_ext, pc_in, pc_stack_pointer;
    ex_pkg::byte_t        load_half_imm;
    ex_pkg::call_target_t call_target;
    ex_pkg::reg_addr_t    reg_rd;
    logic out_valid, reg_write_out, mem_to_reg_out, reg_to_mem_out;
    logic ret_future_out, call_out, pc_update_done, pc_src;
    ex_pkg::reg_addr_t    reg_rd_out;
    ex_pkg::data_t        alu_result, pc_update, sw_data;

    logic [31:0]    lfsr_state;
    ex_pkg::flags_t model_flags;             // Zero, overflow, negative
    ex_pkg::data_t  pend_result, pend_target, pend_sw;
    ex_pkg::data_t  exp_result, exp_target, exp_sw;
    logic           pend_src, pend_done, exp_src, exp_done, exp_valid;
    logic [4:0]     pend_ctrl, exp_ctrl;     // reg_write .. call
    ex_pkg::reg_addr_t pend_rd, exp_rd;
    int error_count, tests_run, tests_failed, issued, test_start;
    logic timeout_hit;

    ex_unit dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;   // 40 ns period
    end

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32 22 2 1
    endfunction

    function automatic logic rand_bit();
        lfsr_state = lfsr_next(lfsr_state);   // One step per bit
        return lfsr_state[0];
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], rand_bit()};
        end
        return r;
    endfunction

    task automatic fill_random();
        rd_data_1        = ex_pkg::data_t'(rand_bits(16));
        rd_data_2        = ex_pkg::data_t'(rand_bits(16));
        sign_ext         = ex_pkg::data_t'(rand_bits(16));
        pc_in            = ex_pkg::data_t'(rand_bits(16));
        pc_stack_pointer = ex_pkg::data_t'(rand_bits(16));
        load_half_imm    = ex_pkg::byte_t'(rand_bits(8));
        call_target      = ex_pkg::call_target_t'(rand_bits(12));
        shift            = ex_pkg::shamt_t'(rand_bits(4));
        reg_rd           = ex_pkg::reg_addr_t'(rand_bits(4));
        alu_op           = ex_pkg::alu_op_e'(rand_bits(3));
        branch_cond      = ex_pkg::branch_cond_e'(rand_bits(3));
        alu_src          = rand_bit();
        half_spec        = rand_bit();
        reg_write        = rand_bit();
        mem_to_reg       = rand_bit();
        reg_to_mem       = rand_bit();
        ret_future       = 1'b0;
        call             = 1'b0;
        ret              = 1'b0;
        branch           = 1'b0;
        load_half        = 1'b0;
    endtask

    //////////////////////////////
    // Reference model
    //////////////////////////////

    task automatic predict();
        ex_pkg::data_t b, res;
        int sa, sb, full;
        logic ovf, cond;
        b = alu_src ? sign_ext : rd_data_2;
        sa = $signed(rd_data_1);
        sb = $signed(b);
        ovf = 1'b0;
        full = (alu_op == ex_pkg::SUB) ? sa - sb : sa + sb;
        case (alu_op)
            ex_pkg::ADD, ex_pkg::SUB: begin
                if (full > 32767) begin
                    res = 16'h7fff;                  // Positive limit
                    ovf = 1'b1;
                end else if (full < -32768) begin
                    res = 16'h8000;                  // Negative limit
                    ovf = 1'b1;
                end else begin
                    res = full[15:0];
                end
            end
            ex_pkg::AND: res = rd_data_1 & b;
            ex_pkg::NOR: res = ~(rd_data_1 | b);
            ex_pkg::SLL: res = rd_data_1 << shift;
            ex_pkg::SRL: res = rd_data_1 >> shift;
            ex_pkg::SRA: res = (rd_data_1 >> shift)
                             | (rd_data_1[15] ? ~(16'hffff >> shift) : 16'h0);
            default:     res = rd_data_1;            // PASS_A
        endcase
        if (load_half) begin
            res = half_spec ? {{8{load_half_imm[7]}}, load_half_imm}
                            : {load_half_imm, rd_data_1[7:0]};
        end
        case (branch_cond)                           // Uses flags of earlier instructions
            ex_pkg::NEQ: cond = !model_flags[2];
            ex_pkg::EQ:  cond = model_flags[2];
            ex_pkg::GT:  cond = !model_flags[2] && !model_flags[0];
            ex_pkg::LT:  cond = model_flags[0];
            ex_pkg::GTE: cond = !model_flags[0];
            ex_pkg::LTE: cond = model_flags[2] || model_flags[0];
            ex_pkg::OVFL: cond = model_flags[1];
            default:     cond = 1'b1;
        endcase
        pend_src = call || ret || (branch && cond);
        if (call) pend_target = {pc_in[15:12], call_target};
        else if (ret) pend_target = pc_stack_pointer;
        else if (branch && cond) pend_target = pc_in + sign_ext;
        else pend_target = pc_in;
        pend_result = res;
        pend_done = branch || call || ret;
        pend_ctrl = {reg_write, mem_to_reg, reg_to_mem, ret_future, call};
        pend_sw = call ? pc_in : rd_data_2;          // Return address stored
        pend_rd = (call || ret_future) ? ex_pkg::reg_addr_t'(`EX_SP_REG) : reg_rd;
        if (!load_half && !pend_done) begin
            model_flags = {res == 16'h0, ovf, res[15]};   // Overflow only from clamping
        end
    endtask

    // One deep queue of expected outputs
    always @(posedge clk) begin
        if (reset) begin
            exp_valid <= 1'b0;
        end else begin
            exp_valid <= in_valid;
            if (in_valid) begin
                exp_result <= pend_result;
                exp_target <= pend_target;
                exp_src    <= pend_src;
                exp_done   <= pend_done;
                exp_ctrl   <= pend_ctrl;
                exp_sw     <= pend_sw;
                exp_rd     <= pend_rd;
            end
        end
    end

    //////////////////////////////
    // Output checks
    //////////////////////////////

    a_valid: assert property (@(posedge clk) disable iff (reset) out_valid == exp_valid)
        else begin
            error_count++;
            $display("error: %0t ns: out_valid %b, expected %b", $time,
                     $sampled(out_valid), $sampled(exp_valid));
        end
    a_latency: assert property (@(posedge clk) disable iff (reset) in_valid |=> out_valid)
        else begin
            error_count++;
            $display("error: %0t ns: accepted instruction did not appear one cycle later", $time);
        end
    a_idle: assert property (@(posedge clk) disable iff (reset)
        !out_valid |-> !(reg_write_out | mem_to_reg_out | reg_to_mem_out | ret_future_out
                         | call_out | pc_update_done | pc_src))
        else begin
            error_count++;
            $display("error: %0t ns: control output high while out_valid low", $time);
        end
    a_result: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> alu_result == exp_result)
        else begin
            error_count++;
            $display("error: %0t ns: alu_result %h, expected %h", $time,
                     $sampled(alu_result), $sampled(exp_result));
        end
    a_flow: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> pc_update == exp_target && pc_src == exp_src && pc_update_done == exp_done)
        else begin
            error_count++;
            $display("error: %0t ns: pc_update %h src %b done %b, expected %h %b %b", $time,
                     $sampled(pc_update), $sampled(pc_src), $sampled(pc_update_done),
                     $sampled(exp_target), $sampled(exp_src), $sampled(exp_done));
        end
    a_ctrl: assert property (@(posedge clk) disable iff (reset) out_valid |->
        {reg_write_out, mem_to_reg_out, reg_to_mem_out, ret_future_out, call_out} == exp_ctrl)
        else begin
            error_count++;
            $display("error: %0t ns: control outputs differ, expected %b", $time, $sampled(exp_ctrl));
        end
    a_store: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> sw_data == exp_sw && reg_rd_out == exp_rd)
        else begin
            error_count++;
            $display("error: %0t ns: sw_data %h reg_rd_out %0d, expected %h %0d", $time,
                     $sampled(sw_data), $sampled(reg_rd_out), $sampled(exp_sw), $sampled(exp_rd));
        end

    //////////////////////////////
    // Sequencing
    //////////////////////////////

    task automatic step();
        @(posedge clk);
        #5;                                         // Drive after the edge
    endtask

    task automatic issue();
        in_valid = 1'b1;
        predict();
        step();
        issued++;
    endtask

    task automatic wait_out();
        int n;
        n = 0;
        while (!out_valid && !timeout_hit) begin
            if (n == 8) begin
                timeout_hit = 1'b1;
                $display("timeout: out_valid never rose at %0t ns", $time);
            end else begin
                step();
                n++;
            end
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        in_valid = 1'b0;
        while (out_valid && !timeout_hit) begin
            if (n == 8) begin
                timeout_hit = 1'b1;
                $display("timeout: out_valid stuck high at %0t ns", $time);
            end else begin
                step();
                n++;
            end
        end
    endtask

    task automatic run_one();
        issue();
        in_valid = 1'b0;
        wait_out();
    endtask

    task automatic report_test(input string name);
        drain();
        tests_run++;
        if (error_count == test_start && !timeout_hit) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, error_count - test_start);
        end
        test_start = error_count;
    endtask

    task automatic set_flags(input ex_pkg::data_t a, input ex_pkg::data_t b);
        fill_random();
        alu_op = ex_pkg::ADD;
        alu_src = 1'b0;
        rd_data_1 = a;
        rd_data_2 = b;
        run_one();
    endtask

    initial begin
        ex_pkg::data_t fa [5] = '{16'h0000, 16'h0005, 16'hfffb, 16'h7fff, 16'h8000};
        ex_pkg::data_t fb [5] = '{16'h0000, 16'h0003, 16'h0000, 16'h0001, 16'hffff};
        $timeformat(-9, 0, "", 0);
        lfsr_state = 32'h13fe_fb6f;
        error_count = 0;
        tests_run = 0;
        tests_failed = 0;
        issued = 0;
        test_start = 0;
        timeout_hit = 1'b0;
        model_flags = '0;
        reset = 1'b1;
        in_valid = 1'b0;
        fill_random();
        repeat (16) step();
        reset = 1'b0;
        repeat (3) step();                          // Idle outputs checked here

        fill_random();
        branch = 1'b1;
        branch_cond = ex_pkg::EQ;                   // Flags cleared, not taken
        run_one();
        report_test("reset and first branch");

        set_flags(16'h7fff, 16'h0001);
        set_flags(16'h8000, 16'h8000);
        for (int i = 0; i < 200; i++) begin
            fill_random();
            if (i == 0) begin
                alu_op = ex_pkg::SUB;
                alu_src = 1'b0;
                rd_data_1 = 16'h8000;
                rd_data_2 = 16'h0001;
            end
            run_one();
        end
        report_test("alu operations");

        for (int i = 0; i < 20; i++) begin
            fill_random();
            load_half = 1'b1;
            half_spec = i[0];                       // LHB and LLB in turn
            run_one();
        end
        report_test("load half");

        for (int s = 0; s < 5; s++) begin
            for (int c = 0; c < 8; c++) begin
                set_flags(fa[s], fb[s]);
                fill_random();
                load_half = 1'b1;                   // Must keep the flags
                run_one();
                repeat (2) begin
                    fill_random();
                    branch = 1'b1;
                    branch_cond = ex_pkg::branch_cond_e'(c);
                    run_one();
                end
            end
        end
        report_test("branch conditions");

        for (int i = 0; i < 10; i++) begin
            fill_random();
            call = 1'b1;
            alu_op = ex_pkg::PASS_A;
            run_one();
        end
        report_test("call");

        for (int i = 0; i < 100; i++) begin
            fill_random();
            case (rand_bits(3))
                3: load_half = 1'b1;
                4: branch = 1'b1;
                5: call = 1'b1;
                6: ret = 1'b1;
                7: ret_future = 1'b1;
                default: ;
            endcase
            issue();                                // Back to back, no gap
        end
        in_valid = 1'b0;
        wait_out();
        report_test("return and back to back");

        $display("tests %0d, failed %0d, instructions %0d, errors %0d",
                 tests_run, tests_failed, issued, error_count);
        if (tests_failed == 0 && error_count == 0 && !timeout_hit) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/alu.sv
// Combinational ALU with saturating add/sub, logic, shifts, load-half and flags
`timescale 1ns/1ps
`default_nettype none

`include "ex_config.svh"

module alu (
    input  ex_pkg::data_t   op_a,          // Operand 1, rd_data_1
    input  ex_pkg::data_t   op_b,          // Operand 2, register or immediate
    input  ex_pkg::shamt_t  shift,         // Shift amount
    input  ex_pkg::alu_op_e alu_op,        // Operation select
    input  logic            load_half,     // Override result with load-half
    input  logic            half_spec,     // 0 -> LHB, 1 -> LLB
    input  ex_pkg::byte_t   load_half_imm, // Load-half immediate
    output ex_pkg::data_t   result,
    output ex_pkg::flags_t  flags          // {zero, overflow, negative}
);

    //////////////////////////////
    // Internal signals
    //////////////////////////////

    logic [`EX_DATA_W:0] sum_ext;       // One guard bit above the sign
    logic                sat_ovfl;      // Guard and sign disagree
    logic                arith_op;      // ADD or SUB selected
    ex_pkg::data_t       sat_result;    // Clamped sum or difference
    ex_pkg::data_t       op_result;     // Result before load-half mux
    ex_pkg::data_t       half_result;   // LHB or LLB value
    logic                flag_z;
    logic                flag_v;
    logic                flag_n;

    //////////////////////////////
    // Saturating add / subtract
    //////////////////////////////

    always_comb begin
        arith_op = (alu_op == ex_pkg::ADD) || (alu_op == ex_pkg::SUB);

        // Sign extend by one bit so the true result always fits
        if (alu_op == ex_pkg::SUB) begin
            sum_ext = {op_a[`EX_DATA_W-1], op_a} - {op_b[`EX_DATA_W-1], op_b};
        end else begin
            sum_ext = {op_a[`EX_DATA_W-1], op_a} + {op_b[`EX_DATA_W-1], op_b};
        end

        sat_ovfl = sum_ext[`EX_DATA_W] ^ sum_ext[`EX_DATA_W-1];

        if (!sat_ovfl) begin
            sat_result = sum_ext[`EX_DATA_W-1:0];                // In range
        end else if (sum_ext[`EX_DATA_W]) begin
            sat_result = {1'b1, {(`EX_DATA_W-1){1'b0}}};         // Clamp to most negative
        end else begin
            sat_result = {1'b0, {(`EX_DATA_W-1){1'b1}}};         // Clamp to most positive
        end
    end

    //////////////////////////////
    // Operation select
    //////////////////////////////

    always_comb begin
        case (alu_op)
            ex_pkg::ADD,
            ex_pkg::SUB:    op_result = sat_result;
            ex_pkg::AND:    op_result = op_a & op_b;
            ex_pkg::NOR:    op_result = ~(op_a | op_b);
            ex_pkg::SLL:    op_result = op_a << shift;
            ex_pkg::SRL:    op_result = op_a >> shift;
            ex_pkg::SRA:    op_result = $signed(op_a) >>> shift; // Sign fills from left
            ex_pkg::PASS_A: op_result = op_a;                    // SP passthrough
            default:        op_result = op_a;
        endcase
    end

    // LHB keeps the low byte, LLB sign extends the immediate
    always_comb begin
        if (half_spec) begin
            half_result = {{(`EX_DATA_W/2){load_half_imm[`EX_DATA_W/2-1]}}, load_half_imm};
        end else begin
            half_result = {load_half_imm, op_a[`EX_DATA_W/2-1:0]};
        end
    end

    assign result = load_half ? half_result : op_result;

    //////////////////////////////
    // Flags
    //////////////////////////////

    assign flag_z = ~|result;                           // Zero result
    assign flag_v = arith_op & sat_ovfl & ~load_half;   // Only on clamp
    assign flag_n = result[`EX_DATA_W-1];               // Sign of result
    assign flags  = {flag_z, flag_v, flag_n};

    // No unknowns can escape from known inputs
    always_comb begin
        if (!$isunknown({op_a, op_b, shift, alu_op, load_half, half_spec, load_half_imm})) begin
            a_result_known: assert final (!$isunknown({result, flags}))
                else $error("alu: unknown result from known inputs");
        end
    end

endmodule

`default_nettype wire

//--- verilog/ex_pkg.sv
// Execute stage vector typedefs, ALU operation and branch condition enums
`default_nettype none

`include "ex_config.svh"

package ex_pkg;

    //////////////////////////////
    // Vector types
    //////////////////////////////

    typedef logic [`EX_DATA_W-1:0]         data_t;        // Data, PC or immediate
    typedef logic [`EX_REG_ADDR_W-1:0]     reg_addr_t;    // Register number
    typedef logic [$clog2(`EX_DATA_W)-1:0] shamt_t;       // Shift amount
    typedef logic [`EX_CALL_W-1:0]         call_target_t; // Absolute call field
    typedef logic [`EX_DATA_W/2-1:0]       byte_t;        // Load-half immediate

    // Bit 2 zero, bit 1 overflow, bit 0 negative
    typedef logic [2:0] flags_t;

    //////////////////////////////
    // Operation encodings
    //////////////////////////////

    typedef enum logic [2:0] {
        ADD    = 3'd0,  // Saturating add
        SUB    = 3'd1,  // Saturating subtract
        AND    = 3'd2,
        NOR    = 3'd3,
        SLL    = 3'd4,  // Logical left
        SRL    = 3'd5,  // Logical right
        SRA    = 3'd6,  // Arithmetic right
        PASS_A = 3'd7   // Stack pointer on call/ret
    } alu_op_e;

    typedef enum logic [2:0] {
        NEQ    = 3'd0,
        EQ     = 3'd1,
        GT     = 3'd2,
        LT     = 3'd3,
        GTE    = 3'd4,
        LTE    = 3'd5,
        OVFL   = 3'd6,
        UNCOND = 3'd7
    } branch_cond_e;

endpackage

`default_nettype wire

//--- verilog/ex_unit.sv
// Execute stage top with operand select, ALU, PC update and EX/MEM register
`timescale 1ns/1ps
`default_nettype none

`include "ex_config.svh"

module ex_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,          // Instruction from decode
    input  logic                 reg_write,
    input  logic                 mem_to_reg,        // Load to memory stage
    input  logic                 reg_to_mem,        // Store to memory stage
    input  logic                 ret_future,        // SP writeback ahead of ret
    input  logic                 call,
    input  logic                 ret,
    input  logic                 branch,
    input  logic                 alu_src,           // 1 selects sign_ext
    input  logic                 load_half,
    input  logic                 half_spec,         // 0 -> LHB, 1 -> LLB
    input  ex_pkg::alu_op_e      alu_op,
    input  ex_pkg::branch_cond_e branch_cond,
    input  ex_pkg::shamt_t       shift,
    input  ex_pkg::data_t        rd_data_1,
    input  ex_pkg::data_t        rd_data_2,
    input  ex_pkg::data_t        sign_ext,
    input  ex_pkg::data_t        pc_in,             // Next sequential PC
    input  ex_pkg::data_t        pc_stack_pointer,
    input  ex_pkg::byte_t        load_half_imm,
    input  ex_pkg::call_target_t call_target,
    output logic                 out_valid,
    output logic                 reg_write_out,
    output logic                 mem_to_reg_out,
    output logic                 reg_to_mem_out,
    output logic                 ret_future_out,
    output logic                 call_out,          // SP decrement downstream
    output logic                 pc_update_done,    // Branch/call/ret resolved
    output logic                 pc_src,            // Take pc_update
    input  ex_pkg::reg_addr_t    reg_rd,
    output ex_pkg::reg_addr_t    reg_rd_out,
    output ex_pkg::data_t        alu_result,
    output ex_pkg::data_t        pc_update,         // Redirect target
    output ex_pkg::data_t        sw_data            // Store word data
);

    //////////////////////////////
    // Operand and field select
    //////////////////////////////

    ex_pkg::data_t     op_b;             // Second ALU operand
    ex_pkg::data_t     alu_result_next;
    ex_pkg::flags_t    alu_flags;
    ex_pkg::data_t     pc_target;
    ex_pkg::data_t     sw_data_next;
    ex_pkg::reg_addr_t reg_rd_next;
    logic              pc_taken;
    logic              flags_we;         // Plain ALU instruction

    assign op_b = alu_src ? sign_ext : rd_data_2;

    // Branches, calls, returns and load-half keep the flags
    assign flags_we = in_valid & ~load_half & ~(branch | call | ret);

    assign sw_data_next = call ? pc_in : rd_data_2;   // Return address pushed on call

    // Stack pointer is the destination for call and ret_future
    assign reg_rd_next = (call | ret_future) ? ex_pkg::reg_addr_t'(`EX_SP_REG) : reg_rd;

    //////////////////////////////
    // ALU and PC update
    //////////////////////////////

    alu alu_i (
        .op_a          (rd_data_1),
        .op_b          (op_b),
        .shift         (shift),
        .alu_op        (alu_op),
        .load_half     (load_half),
        .half_spec     (half_spec),
        .load_half_imm (load_half_imm),
        .result        (alu_result_next),
        .flags         (alu_flags)
    );

    pc_update pc_update_i (
        .clk              (clk),
        .reset            (reset),
        .flags_we         (flags_we),
        .alu_flags        (alu_flags),
        .branch           (branch),
        .call             (call),
        .ret              (ret),
        .branch_cond      (branch_cond),
        .pc_in            (pc_in),
        .sign_ext         (sign_ext),
        .call_target      (call_target),
        .pc_stack_pointer (pc_stack_pointer),
        .pc_target        (pc_target),
        .pc_taken         (pc_taken)
    );

    //////////////////////////////
    // EX/MEM register
    //////////////////////////////

    // Control half, cleared on reset and on an empty slot
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid      <= 1'b0;
            reg_write_out  <= 1'b0;
            mem_to_reg_out <= 1'b0;
            reg_to_mem_out <= 1'b0;
            ret_future_out <= 1'b0;
            call_out       <= 1'b0;
            pc_update_done <= 1'b0;
            pc_src         <= 1'b0;
        end else begin
            out_valid      <= in_valid;
            reg_write_out  <= in_valid & reg_write;
            mem_to_reg_out <= in_valid & mem_to_reg;
            reg_to_mem_out <= in_valid & reg_to_mem;
            ret_future_out <= in_valid & ret_future;
            call_out       <= in_valid & call;
            pc_update_done <= in_valid & (branch | call | ret);  // Any transfer
            pc_src         <= in_valid & pc_taken;
        end
    end

    // Payload half, held between valid instructions
    always_ff @(posedge clk) begin
        if (in_valid) begin
            alu_result <= alu_result_next;
            pc_update  <= pc_target;
            sw_data    <= sw_data_next;
            reg_rd_out <= reg_rd_next;
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    a_reset_idle: assert property (
        @(posedge clk) reset |=> !out_valid
    ) else $error("ex_unit: out_valid high after reset");

endmodule

`default_nettype wire

//--- verilog/pc_update.sv
// Flag register, branch condition check and PC target selection
`timescale 1ns/1ps
`default_nettype none

`include "ex_config.svh"

module pc_update (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flags_we,         // Load flags from ALU
    input  ex_pkg::flags_t       alu_flags,        // {zero, overflow, negative}
    input  logic                 branch,
    input  logic                 call,
    input  logic                 ret,
    input  ex_pkg::branch_cond_e branch_cond,
    input  ex_pkg::data_t        pc_in,            // Next sequential PC
    input  ex_pkg::data_t        sign_ext,         // Branch offset
    input  ex_pkg::call_target_t call_target,      // Absolute call field
    input  ex_pkg::data_t        pc_stack_pointer, // Return address
    output ex_pkg::data_t        pc_target,
    output logic                 pc_taken          // Redirect fetch
);

    //////////////////////////////
    // Flag register
    //////////////////////////////

    ex_pkg::flags_t flags_q;   // Flags of earlier instructions
    logic           flag_z;
    logic           flag_v;
    logic           flag_n;
    logic           cond_met;  // Branch condition holds

    always_ff @(posedge clk) begin
        if (reset) begin
            flags_q <= '0;
        end else if (flags_we) begin
            flags_q <= alu_flags;   // Same edge that accepts the instruction
        end
    end

    assign flag_z = flags_q[2];
    assign flag_v = flags_q[1];
    assign flag_n = flags_q[0];

    //////////////////////////////
    // Condition evaluation
    //////////////////////////////

    always_comb begin
        case (branch_cond)
            ex_pkg::NEQ:    cond_met = ~flag_z;
            ex_pkg::EQ:     cond_met = flag_z;
            ex_pkg::GT:     cond_met = ~flag_z & ~flag_n;  // Strictly positive
            ex_pkg::LT:     cond_met = flag_n;
            ex_pkg::GTE:    cond_met = ~flag_n;
            ex_pkg::LTE:    cond_met = flag_z | flag_n;
            ex_pkg::OVFL:   cond_met = flag_v;             // Last add/sub clamped
            ex_pkg::UNCOND: cond_met = 1'b1;
            default:        cond_met = 1'b0;
        endcase
    end

    //////////////////////////////
    // Target selection
    //////////////////////////////

    always_comb begin
        pc_taken  = 1'b0;
        pc_target = pc_in;   // Fall through
        if (call) begin
            // Keep the current page, replace the offset
            pc_target = {pc_in[`EX_DATA_W-1:`EX_CALL_W], call_target};
            pc_taken  = 1'b1;
        end else if (ret) begin
            pc_target = pc_stack_pointer;
            pc_taken  = 1'b1;
        end else if (branch && cond_met) begin
            pc_target = pc_in + sign_ext;   // PC relative
            pc_taken  = 1'b1;
        end
    end

    // Decode never issues more than one kind of control transfer
    a_one_transfer: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0({branch, call, ret})
    ) else $error("pc_update: more than one of branch, call, ret");

endmodule

`default_nettype wire
